// File: list.f
logic/blur_pkg.sv
logic/window_if.sv
logic/row_mem.sv
logic/blur_ctrl.sv
logic/line_buffer.sv
logic/blur_lane.sv
logic/row_drain.sv
logic/blur_core.sv
tests/blur_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the blur core testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module blur_core_tb

./obj_dir/Vblur_core_tb > sim.log 2>&1

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

echo "simulation clean, see sim.log"

// File: tests/blur_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module blur_core_tb;
    import blur_pkg::*;

    localparam int CLK_PERIOD = 40;  // ns
    localparam int RUN_BOUND  = 64;  // cycles from start to done
    localparam int NUM_CASES  = 6;

    typedef enum int {PAT_ZERO, PAT_CONST, PAT_IMPULSE, PAT_RAMP, PAT_RANDOM} pat_t;

    // case table applied in order, each run starts from done of the one before
    string case_name [NUM_CASES] = '{"zero", "const_255", "impulse_160",
                                     "ramp_7", "random", "zero_rerun"};
    pat_t  case_kind [NUM_CASES] = '{PAT_ZERO, PAT_CONST, PAT_IMPULSE,
                                     PAT_RAMP, PAT_RANDOM, PAT_ZERO};
    int    case_val  [NUM_CASES] = '{0, 255, 160, 7, 0, 0};

    logic      clk = 1'b0;
    logic      rst_n;
    logic      start;
    logic      done;
    logic      img_we;
    row_addr_t img_addr;
    row_t      img_din;
    row_addr_t blur_rd_addr;
    row_t      blur_rd_data;

    row_t img [IMG_H];   // image as last loaded into the DUT
    int   seed = 54705;
    int   pass_cnt = 0;
    int   fail_cnt = 0;

    blur_core DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .done         (done),
        .img_we       (img_we),
        .img_addr     (img_addr),
        .img_din      (img_din),
        .blur_rd_addr (blur_rd_addr),
        .blur_rd_data (blur_rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_row(input string name, input row_t expected, input row_t actual);
        if (actual === expected) begin
            pass_cnt++;
            $display("[PASS] %s", name);
        end else begin
            fail_cnt++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual === expected) begin
            pass_cnt++;
            $display("[PASS] %s", name);
        end else begin
            fail_cnt++;
            $display("[FAIL] %s expected %b actual %b", name, expected, actual);
        end
    endtask

    function automatic int pix_at(input int r, input int c);
        if (r < 0 || r >= IMG_H || c < 0 || c >= IMG_W) begin
            return 0;  // zero fill outside the image
        end
        return int'(img[r][c]);
    endfunction

    // reference 3x3 gaussian from the kernel rule
    function automatic row_t blur_ref(input int r);
        row_t res;
        int   acc;
        int   w;
        for (int c = 0; c < IMG_W; c++) begin
            acc = 0;
            for (int dr = -1; dr <= 1; dr++) begin
                for (int dc = -1; dc <= 1; dc++) begin
                    w   = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);  // 1 2 1 outer product
                    acc += w * pix_at(r + dr, c + dc);
                end
            end
            res[c] = pixel_t'(acc >> KERNEL_SHIFT);  // truncating divide by 16
        end
        return res;
    endfunction

    task automatic build_image(input pat_t kind, input int val);
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                case (kind)
                    PAT_CONST:   img[r][c] = pixel_t'(val);
                    PAT_IMPULSE: img[r][c] = (r == 5 && c == 9) ? pixel_t'(val) : '0;
                    PAT_RAMP:    img[r][c] = pixel_t'((r * IMG_W + c) * val);  // wraps mod 256
                    PAT_RANDOM:  img[r][c] = pixel_t'($random(seed));
                    default:     img[r][c] = '0;
                endcase
            end
        end
    endtask

    task automatic load_image();
        for (int r = 0; r < IMG_H; r++) begin
            @(negedge clk);
            img_we   = 1'b1;
            img_addr = row_addr_t'(r);
            img_din  = img[r];
        end
        @(negedge clk);
        img_we = 1'b0;
    endtask

    task automatic run_blur(input string name, output bit finished);
        int waited;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_level({name, " done falls after start"}, 1'b0, done);
        waited = 0;
        while (!done && waited < RUN_BOUND) begin  // bounded wait for done
            @(negedge clk);
            waited++;
        end
        finished = done;
        if (!done) begin
            fail_cnt++;
            $display("%s: done did not rise within %0d cycles of start", name, RUN_BOUND);
        end
    endtask

    task automatic read_back(input string name);
        for (int r = 0; r < IMG_H; r++) begin
            @(negedge clk);
            blur_rd_addr = row_addr_t'(r);
            @(negedge clk);  // registered read
            check_row($sformatf("%s row %0d", name, r), blur_ref(r), blur_rd_data);
        end
    endtask

    initial begin
        bit finished;
        rst_n        = 1'b0;
        start        = 1'b0;
        img_we       = 1'b0;
        img_addr     = '0;
        img_din      = '0;
        blur_rd_addr = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin  // no start yet, done stays low
            @(negedge clk);
            check_level("idle done low", 1'b0, done);
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            build_image(case_kind[i], case_val[i]);
            load_image();
            run_blur(case_name[i], finished);
            if (finished) begin
                read_back(case_name[i]);
                check_level({case_name[i], " done holds"}, 1'b1, done);
            end
        end
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // whole-run bound: load, run and readback per case
    initial begin
        #(NUM_CASES * (IMG_H + IMG_H + RUN_BOUND) * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/blur_core.sv
`timescale 1ns/1ps
`default_nettype none

module blur_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    output logic                done,
    input  logic                img_we,
    input  blur_pkg::row_addr_t img_addr,
    input  blur_pkg::row_t      img_din,
    input  blur_pkg::row_addr_t blur_rd_addr,
    output blur_pkg::row_t      blur_rd_data
);
    import blur_pkg::*;

    row_addr_t img_rd_addr;
    row_t      img_rd_data;
    logic      shift_in;
    logic      flush;
    logic      last_written;
    logic      blur_we;
    row_addr_t blur_wr_addr;
    row_t      blur_wr_data;
    pixel_t    lane_pix [IMG_W];

    window_if win ();

    row_mem img_mem (                   // host writes, ctrl reads
        .clk     (clk),
        .we      (img_we),
        .wr_addr (img_addr),
        .wr_data (img_din),
        .rd_addr (img_rd_addr),
        .rd_data (img_rd_data)
    );

    row_mem blur_mem (                  // drain writes, host reads
        .clk     (clk),
        .we      (blur_we),
        .wr_addr (blur_wr_addr),
        .wr_data (blur_wr_data),
        .rd_addr (blur_rd_addr),
        .rd_data (blur_rd_data)
    );

    blur_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .last_written (last_written),
        .img_rd_addr  (img_rd_addr),
        .shift_in     (shift_in),
        .flush        (flush),
        .done         (done)
    );

    line_buffer u_line_buf (
        .clk      (clk),
        .rst_n    (rst_n),
        .shift_in (shift_in),
        .flush    (flush),
        .row_in   (img_rd_data),
        .win      (win)
    );

    for (genvar c = 0; c < IMG_W; c++) begin : lanes
        blur_lane #(
            .COL (c)
        ) u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .win     (win),
            .pix_out (lane_pix[c])
        );
    end

    row_drain u_drain (
        .clk          (clk),
        .rst_n        (rst_n),
        .win_valid    (win.win_valid),
        .win_row      (win.win_row),
        .lane_pix     (lane_pix),
        .blur_we      (blur_we),
        .blur_wr_addr (blur_wr_addr),
        .blur_wr_data (blur_wr_data),
        .last_written (last_written)
    );

endmodule

`default_nettype wire

// File: logic/row_drain.sv
`timescale 1ns/1ps
`default_nettype none

module row_drain (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                win_valid,
    input  blur_pkg::row_addr_t win_row,
    input  blur_pkg::pixel_t    lane_pix [blur_pkg::IMG_W],
    output logic                blur_we,
    output blur_pkg::row_addr_t blur_wr_addr,
    output blur_pkg::row_t      blur_wr_data,
    output logic                last_written
);
    import blur_pkg::*;

    logic      valid_q;  // lines up with lane outputs
    row_addr_t row_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q      <= 1'b0;
            last_written <= 1'b0;
        end else begin
            valid_q      <= win_valid;
            last_written <= valid_q && (row_q == row_addr_t'(IMG_H - 1));  // after final write
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            row_q <= win_row;
        end
    end

    always_comb begin
        for (int c = 0; c < IMG_W; c++) begin
            blur_wr_data[c] = lane_pix[c];  // lane c into column c
        end
    end

    assign blur_we      = valid_q;
    assign blur_wr_addr = row_q;

    // rows arrive back to back and in order once a run is going
    a_row_order : assert property (
        @(posedge clk) disable iff (!rst_n)
        (blur_we && row_q != '0) |-> ($past(blur_we) && $past(row_q) == row_q - 1'b1)
    ) else $error("blur row %0d written out of order", row_q);

endmodule

`default_nettype wire

// File: logic/blur_lane.sv
`timescale 1ns/1ps
`default_nettype none

module blur_lane #(
    parameter int COL = 0  // column handled by this lane
) (
    input  logic             clk,
    input  logic             rst_n,
    window_if.sink           win,
    output blur_pkg::pixel_t pix_out
);
    import blur_pkg::*;

    typedef pixel_t [IMG_W+1:0] padded_t;  // row with a zero pixel on each side

    padded_t   above_x;
    padded_t   center_x;
    padded_t   below_x;
    lane_sum_t sum;

    // 1 2 1 taps around this column, col c sits at index c+1
    function automatic lane_sum_t tap3(input padded_t r);
        return lane_sum_t'(r[COL]) + (lane_sum_t'(r[COL+1]) << 1) + lane_sum_t'(r[COL+2]);
    endfunction

    assign above_x  = {pixel_t'(0), win.above, pixel_t'(0)};
    assign center_x = {pixel_t'(0), win.center, pixel_t'(0)};
    assign below_x  = {pixel_t'(0), win.below, pixel_t'(0)};

    assign sum = tap3(above_x) + (tap3(center_x) << 1) + tap3(below_x);  // 1 2 1 vertical

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_out <= '0;
        end else if (win.win_valid) begin
            pix_out <= pixel_t'(sum >> KERNEL_SHIFT);  // truncating normalize
        end
    end

    // window data from the buffer must stay within kernel range
    a_sum_range : assert property (
        @(posedge clk) disable iff (!rst_n) win.win_valid |-> sum <= SUM_MAX
    ) else $error("lane %0d sum out of range", COL);

endmodule

`default_nettype wire

// File: logic/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           shift_in,
    input  logic           flush,
    input  blur_pkg::row_t row_in,
    window_if.source       win
);
    import blur_pkg::*;

    row_t      top_q;    // oldest row
    row_t      mid_q;
    row_t      bot_q;    // newest row
    row_addr_t cnt_q;    // rows shifted in this run, mod IMG_H
    row_addr_t row_q;    // center row index
    logic      valid_q;
    logic      shift;
    logic      first;

    assign shift = shift_in || flush;
    assign first = shift_in && (cnt_q == '0);  // row 0 entering, nothing above it

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= flush || (shift_in && cnt_q != '0);  // from row 1 on, plus flush
            if (flush) begin
                cnt_q <= '0;
            end else if (shift_in) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            top_q <= mid_q;
            mid_q <= first ? '0 : bot_q;   // zero fill above row 0
            bot_q <= flush ? '0 : row_in;  // zero fill below last row
            row_q <= cnt_q - 1'b1;         // flush wraps to IMG_H-1
        end
    end

    assign win.above     = top_q;
    assign win.center    = mid_q;
    assign win.below     = bot_q;
    assign win.win_valid = valid_q;
    assign win.win_row   = row_q;

endmodule

`default_nettype wire

// File: logic/blur_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module blur_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                last_written,
    output blur_pkg::row_addr_t img_rd_addr,
    output logic                shift_in,
    output logic                flush,
    output logic                done
);
    import blur_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,   // waiting for first start
        ST_READ,   // one image row read per cycle
        ST_FLUSH,  // last row still in flight
        ST_DRAIN,  // pipeline emptying into blur mem
        ST_DONE    // result valid, start accepted again
    } state_t;

    state_t    state_q;
    row_addr_t row_cnt_q;  // next image row to read

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            row_cnt_q <= '0;
            shift_in  <= 1'b0;
            flush     <= 1'b0;
        end else begin
            shift_in <= (state_q == ST_READ);   // read data lands next cycle
            flush    <= (state_q == ST_FLUSH);  // one slot after the last shift
            case (state_q)
                ST_IDLE, ST_DONE: begin
                    if (start) begin
                        state_q   <= ST_READ;
                        row_cnt_q <= '0;
                    end
                end
                ST_READ: begin
                    row_cnt_q <= row_cnt_q + 1'b1;  // wraps to 0 after last row
                    if (row_cnt_q == row_addr_t'(IMG_H - 1)) begin
                        state_q <= ST_FLUSH;
                    end
                end
                ST_FLUSH: begin
                    state_q <= ST_DRAIN;
                end
                ST_DRAIN: begin
                    if (last_written) begin
                        state_q <= ST_DONE;  // last blurred row is in memory
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign img_rd_addr = row_cnt_q;
    assign done        = (state_q == ST_DONE);  // level until next start

    // the zero row must never collide with a real row in the line buffer
    a_shift_flush_excl : assert property (
        @(posedge clk) disable iff (!rst_n) !(shift_in && flush)
    ) else $error("shift_in and flush high together");

endmodule

`default_nettype wire

// File: logic/row_mem.sv
`timescale 1ns/1ps
`default_nettype none

module row_mem (
    input  logic                clk,
    input  logic                we,
    input  blur_pkg::row_addr_t wr_addr,
    input  blur_pkg::row_t      wr_data,
    input  blur_pkg::row_addr_t rd_addr,
    output blur_pkg::row_t      rd_data
);
    import blur_pkg::*;

    row_t mem [IMG_H];  // one image row per word

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;  // full row per write
        end
        rd_data <= mem[rd_addr];      // registered read, 1 cycle
    end

    // host or drain must never write through a floating address
    a_wr_addr_known : assert property (@(posedge clk) we |-> !$isunknown(wr_addr))
        else $error("row_mem write with unknown address");

endmodule

`default_nettype wire

// File: logic/window_if.sv
`timescale 1ns/1ps
`default_nettype none

interface window_if;

    blur_pkg::row_t      above;      // row above center, zero above row 0
    blur_pkg::row_t      center;
    blur_pkg::row_t      below;      // zero below the last row
    logic                win_valid;  // one-cycle strobe per window
    blur_pkg::row_addr_t win_row;    // index of the center row

    modport source (
        output above, center, below, win_valid, win_row
    );

    modport sink (
        input above, center, below, win_valid, win_row
    );

endinterface

`default_nettype wire

// File: logic/blur_pkg.sv
`default_nettype none

package blur_pkg;

    localparam int PIX_W        = 8;   // bits per pixel
    localparam int IMG_W        = 16;  // pixels per row, also lane count
    localparam int IMG_H        = 16;  // rows per image
    localparam int ROW_ADDR_W   = 4;   // one word per row
    localparam int KERNEL_SHIFT = 4;   // kernel weights add up to 16
    localparam int SUM_W        = 12;  // 16 * 255 fits in 12 bits

    typedef logic [PIX_W-1:0]      pixel_t;
    typedef pixel_t [IMG_W-1:0]    row_t;       // column 0 in the low byte
    typedef logic [ROW_ADDR_W-1:0] row_addr_t;
    typedef logic [SUM_W-1:0]      lane_sum_t;  // raw weighted sum before the shift

    // largest sum the 1 2 1 / 2 4 2 / 1 2 1 kernel can produce
    localparam lane_sum_t SUM_MAX = lane_sum_t'(16 * (2**PIX_W - 1));

endpackage

`default_nettype wire
